//--- dcache.f
design/dcache_pkg.sv
design/dcache_mem_port.sv
design/dcache_data_array.sv
design/dcache_tag_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

//--- design/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid_i,
    input  dcache_pkg::core_req_t         req_i,
    input  logic                          flush_i,
    input  logic                          hit_i,
    input  logic                          hit_way_i,
    input  logic                          victim_way_i,
    input  logic                          victim_dirty_i,
    input  logic                          victim_valid_i,
    input  logic [dcache_pkg::TAG_W-1:0]  victim_tag_i,
    input  logic                          mem_done_i,
    output logic                          done_o,
    output logic                          flush_done_o,
    output dcache_pkg::line_sel_t         sel_o,
    output dcache_pkg::core_req_t         req_o,
    output logic                          tag_we_o,
    output logic                          lru_touch_o,
    output logic                          clean_o,
    output logic                          inval_all_o,
    output logic                          data_we_o,
    output logic                          fill_o,
    output logic                          mem_rd_start_o,
    output logic                          mem_wr_start_o,
    output logic [dcache_pkg::ADDR_W-1:0] wb_addr_o
);
    import dcache_pkg::*;

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    core_req_t        req_q;
    logic [INDEX_W:0] cnt_q;       // {set, way} walked by flush
    logic             cnt_last;
    logic             flush_walk;
    logic             accept;

    assign accept     = (state_q == ST_IDLE) && !flush_i && req_valid_i;
    assign flush_walk = (state_q == ST_FLUSH_CHECK) || (state_q == ST_FLUSH_WB);
    assign cnt_last   = (cnt_q == SLOTS - 1);
    assign req_o      = req_q;

    // flush walks the counter, otherwise hit way or the LRU victim
    assign sel_o.index = flush_walk ? cnt_q[INDEX_W:1] : req_q.addr[OFFSET_W +: INDEX_W];
    assign sel_o.way   = flush_walk ? cnt_q[0] : (hit_i ? hit_way_i : victim_way_i);
    assign wb_addr_o   = {victim_tag_i, sel_o.index, {OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                cnt_q <= '0;
            end else if (state_q == ST_FLUSH_CHECK && !(victim_valid_i && victim_dirty_i)) begin
                cnt_q <= cnt_q + 1'b1;    // clean slot, skip it
            end else if (state_q == ST_FLUSH_WB && mem_done_i) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        state_d        = state_q;
        done_o         = 1'b0;
        flush_done_o   = 1'b0;
        tag_we_o       = 1'b0;
        lru_touch_o    = 1'b0;
        clean_o        = 1'b0;
        inval_all_o    = 1'b0;
        data_we_o      = 1'b0;
        fill_o         = 1'b0;
        mem_rd_start_o = 1'b0;
        mem_wr_start_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (flush_i) begin
                    state_d = ST_FLUSH_CHECK;
                end else if (req_valid_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit_i) begin
                    done_o      = 1'b1;
                    lru_touch_o = 1'b1;
                    data_we_o   = (req_q.op == OP_WRITE);
                    state_d     = ST_IDLE;
                end else if (victim_valid_i && victim_dirty_i) begin
                    mem_wr_start_o = 1'b1;
                    state_d        = ST_WRITEBACK;
                end else begin
                    mem_rd_start_o = 1'b1;
                    state_d        = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_done_i) begin
                    mem_rd_start_o = 1'b1;
                    state_d        = ST_REFILL;
                end
            end
            ST_REFILL: begin
                fill_o = 1'b1;
                if (mem_done_i) begin
                    tag_we_o  = 1'b1;
                    data_we_o = 1'b1;
                    state_d   = ST_LOOKUP;   // finish as a hit
                end
            end
            ST_FLUSH_CHECK: begin
                if (victim_valid_i && victim_dirty_i) begin
                    mem_wr_start_o = 1'b1;
                    state_d        = ST_FLUSH_WB;
                end else if (cnt_last) begin
                    state_d = ST_FLUSH_DONE;
                end
            end
            ST_FLUSH_WB: begin
                if (mem_done_i) begin
                    clean_o = 1'b1;
                    state_d = cnt_last ? ST_FLUSH_DONE : ST_FLUSH_CHECK;
                end
            end
            ST_FLUSH_DONE: begin
                inval_all_o  = 1'b1;
                flush_done_o = 1'b1;
                state_d      = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // the memory port holds one transaction at a time
    done_in_wait: assert property (@(posedge clk) disable iff (rst)
        mem_done_i |-> (state_q == ST_WRITEBACK) || (state_q == ST_REFILL) ||
                       (state_q == ST_FLUSH_WB))
        else $error("memory completion while no transaction was waited on");

endmodule

`default_nettype wire

//--- design/dcache_data_array.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_data_array (
    input  logic                          clk,
    input  dcache_pkg::line_sel_t         sel_i,
    input  dcache_pkg::core_req_t         req_i,
    input  logic                          we_i,
    input  logic                          fill_i,
    input  logic [dcache_pkg::LINE_W-1:0] fill_line_i,
    output logic [dcache_pkg::LINE_W-1:0] line_o,
    output logic [dcache_pkg::WORD_W-1:0] rdata_o
);
    import dcache_pkg::*;

    logic [LINE_W-1:0]                   lines_q [SLOTS];
    logic [LINE_W-1:0]                   wr_line;
    logic [$clog2(WORDS_PER_LINE)-1:0]   word_sel;

    assign word_sel = req_i.addr[OFFSET_W-1:3];   // addr[4:3]
    assign line_o   = lines_q[sel_i];
    assign rdata_o  = line_o[word_sel*WORD_W +: WORD_W];

    // base is the refill line on a miss, else the stored line
    always_comb begin
        wr_line = fill_i ? fill_line_i : line_o;
        if (req_i.op == OP_WRITE) begin
            for (int b = 0; b < WSEL_W; b++) begin
                if (req_i.wsel[b]) begin
                    wr_line[word_sel*WORD_W + b*8 +: 8] = req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            lines_q[sel_i] <= wr_line;
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_mem_port.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_port (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_start_i,
    input  logic                          wr_start_i,
    input  logic [dcache_pkg::ADDR_W-1:0] rd_addr_i,
    input  dcache_pkg::mem_wr_t           wr_i,
    input  logic                          mem_rd_ack_i,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rd_line_i,
    input  logic                          mem_wr_ack_i,
    output logic                          mem_rd_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr_o,
    output logic                          mem_wr_req_o,
    output dcache_pkg::mem_wr_t           mem_wr_o,
    output logic [dcache_pkg::LINE_W-1:0] fill_line_o,
    output logic                          mem_done_o
);
    import dcache_pkg::*;

    logic              rd_ack;
    logic              wr_ack;

    assign rd_ack      = mem_rd_req_o && mem_rd_ack_i;
    assign wr_ack      = mem_wr_req_o && mem_wr_ack_i;
    assign mem_done_o  = rd_ack || wr_ack;
    assign fill_line_o = mem_rd_line_i;   // array takes it in the ack cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rd_req_o <= 1'b0;
            mem_wr_req_o <= 1'b0;
        end else begin
            if (rd_start_i) begin
                mem_rd_req_o <= 1'b1;
            end else if (rd_ack) begin
                mem_rd_req_o <= 1'b0;
            end
            if (wr_start_i) begin
                mem_wr_req_o <= 1'b1;
            end else if (wr_ack) begin
                mem_wr_req_o <= 1'b0;
            end
        end
    end

    // payloads, held steady while the request is up
    always_ff @(posedge clk) begin
        if (rd_start_i) begin
            mem_rd_addr_o <= rd_addr_i;
        end
        if (wr_start_i) begin
            mem_wr_o <= wr_i;
        end
    end

    rd_held: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req_o && !mem_rd_ack_i |=> mem_rd_req_o && $stable(mem_rd_addr_o))
        else $error("read request dropped or moved before ack");

    wr_held: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req_o && !mem_wr_ack_i |=> mem_wr_req_o && $stable(mem_wr_o.addr))
        else $error("write request dropped or moved before ack");

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 64;
    localparam int WSEL_W         = WORD_W / 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int OFFSET_W       = 5;     // 32-byte lines
    localparam int SETS           = 64;
    localparam int INDEX_W        = 6;
    localparam int WAYS           = 2;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SLOTS          = SETS * WAYS;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,     // dirty victim going out
        ST_REFILL,        // waiting for the line
        ST_FLUSH_CHECK,
        ST_FLUSH_WB,
        ST_FLUSH_DONE
    } ctrl_state_e;

    // one core access, wdata already lane aligned
    typedef struct packed {
        cache_op_e           op;
        logic [ADDR_W-1:0]   addr;
        logic [WORD_W-1:0]   wdata;
        logic [WSEL_W-1:0]   wsel;
    } core_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;    // line aligned
        logic [LINE_W-1:0]   line;
    } mem_wr_t;

    // one line slot, also the flush walk position
    typedef struct packed {
        logic [INDEX_W-1:0]  index;
        logic                way;
    } line_sel_t;

endpackage

`default_nettype wire

//--- design/dcache_tag_array.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_array (
    input  logic                         clk,
    input  logic                         rst,
    input  dcache_pkg::line_sel_t        sel_i,
    input  logic [dcache_pkg::TAG_W-1:0] tag_i,
    input  logic                         tag_we_i,
    input  logic                         lru_touch_i,
    input  logic                         dirty_set_i,
    input  logic                         clean_i,
    input  logic                         inval_all_i,
    output logic                         hit_o,
    output logic                         hit_way_o,
    output logic                         victim_way_o,
    output logic                         victim_dirty_o,
    output logic                         victim_valid_o,
    output logic [dcache_pkg::TAG_W-1:0] victim_tag_o
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]           tags_q [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]  valid_q;
    logic [WAYS-1:0][SETS-1:0]  dirty_q;
    logic [SETS-1:0]            lru_q;     // points at the next victim
    logic [WAYS-1:0]            match;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_q[w][sel_i.index] && (tags_q[w][sel_i.index] == tag_i);
        end
    end

    assign hit_o     = |match;
    assign hit_way_o = match[1];

    // victim fields describe whichever slot sel_i names
    assign victim_way_o   = lru_q[sel_i.index];
    assign victim_valid_o = valid_q[sel_i.way][sel_i.index];
    assign victim_dirty_o = dirty_q[sel_i.way][sel_i.index];
    assign victim_tag_o   = tags_q[sel_i.way][sel_i.index];

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tags_q[sel_i.way][sel_i.index] <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || inval_all_i) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (tag_we_i) begin
                valid_q[sel_i.way][sel_i.index] <= 1'b1;
            end
            if (tag_we_i || clean_i) begin
                dirty_q[sel_i.way][sel_i.index] <= 1'b0;   // refill or flushed
            end else if (dirty_set_i) begin
                dirty_q[sel_i.way][sel_i.index] <= 1'b1;
            end
            if (lru_touch_i) begin
                lru_q[sel_i.index] <= ~sel_i.way;
            end
        end
    end

    // refill only ever targets a way that does not hold the tag
    single_match: assert property (@(posedge clk) disable iff (rst)
        !(&match))
        else $error("tag present in both ways");

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid_i,
    input  dcache_pkg::core_req_t         req_i,
    input  logic                          flush_i,
    input  logic                          mem_rd_ack_i,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rd_line_i,
    input  logic                          mem_wr_ack_i,
    output logic                          done_o,
    output logic [dcache_pkg::WORD_W-1:0] rdata_o,
    output logic                          flush_done_o,
    output logic                          mem_rd_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr_o,
    output logic                          mem_wr_req_o,
    output dcache_pkg::mem_wr_t           mem_wr_o
);
    import dcache_pkg::*;

    line_sel_t          sel;
    core_req_t          req_q;
    logic               hit;
    logic               hit_way;
    logic               victim_way;
    logic               victim_dirty;
    logic               victim_valid;
    logic [TAG_W-1:0]   victim_tag;
    logic               tag_we;
    logic               lru_touch;
    logic               clean;
    logic               inval_all;
    logic               data_we;
    logic               fill;
    logic               rd_start;
    logic               wr_start;
    logic               mem_done;
    logic [ADDR_W-1:0]  wb_addr;
    logic [LINE_W-1:0]  line;
    logic [LINE_W-1:0]  fill_line;

    dcache_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .flush_i        (flush_i),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_valid_i (victim_valid),
        .victim_tag_i   (victim_tag),
        .mem_done_i     (mem_done),
        .done_o         (done_o),
        .flush_done_o   (flush_done_o),
        .sel_o          (sel),
        .req_o          (req_q),
        .tag_we_o       (tag_we),
        .lru_touch_o    (lru_touch),
        .clean_o        (clean),
        .inval_all_o    (inval_all),
        .data_we_o      (data_we),
        .fill_o         (fill),
        .mem_rd_start_o (rd_start),
        .mem_wr_start_o (wr_start),
        .wb_addr_o      (wb_addr)
    );

    // a data write is a store or a refill, the refill clears dirty itself
    dcache_tag_array tag_i (
        .clk            (clk),
        .rst            (rst),
        .sel_i          (sel),
        .tag_i          (req_q.addr[ADDR_W-1 -: TAG_W]),
        .tag_we_i       (tag_we),
        .lru_touch_i    (lru_touch),
        .dirty_set_i    (data_we),
        .clean_i        (clean),
        .inval_all_i    (inval_all),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_valid_o (victim_valid),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_array data_i (
        .clk         (clk),
        .sel_i       (sel),
        .req_i       (req_q),
        .we_i        (data_we),
        .fill_i      (fill),
        .fill_line_i (fill_line),
        .line_o      (line),
        .rdata_o     (rdata_o)
    );

    dcache_mem_port mem_port_i (
        .clk           (clk),
        .rst           (rst),
        .rd_start_i    (rd_start),
        .wr_start_i    (wr_start),
        .rd_addr_i     ({req_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}),
        .wr_i          ({wb_addr, line}),
        .mem_rd_ack_i  (mem_rd_ack_i),
        .mem_rd_line_i (mem_rd_line_i),
        .mem_wr_ack_i  (mem_wr_ack_i),
        .mem_rd_req_o  (mem_rd_req_o),
        .mem_rd_addr_o (mem_rd_addr_o),
        .mem_wr_req_o  (mem_wr_req_o),
        .mem_wr_o      (mem_wr_o),
        .fill_line_o   (fill_line),
        .mem_done_o    (mem_done)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module dcache_tb -f dcache.f
output="$(./obj_dir/Vdcache_tb)"
echo "$output"
if grep -qx "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1

//--- sim/dcache_cases.txt
// op (0 read, 1 write, 2 flush), addr, wdata, wsel, expected rdata (reads only),
// expected running count of memory line reads after the op
0 00000100 0000000000000000 00 00000100fffffeff 1
0 00000118 0000000000000000 00 00000118fffffee7 1
1 00000110 1122334455667788 0f 0000000000000000 1
0 00000110 0000000000000000 00 0000011055667788 1
1 00000208 aabbccddeeff0011 f0 0000000000000000 2
0 00000208 0000000000000000 00 aabbccddfffffdf7 2
0 00001040 0000000000000000 00 00001040ffffefbf 3
0 00001840 0000000000000000 00 00001840ffffe7bf 4
0 00001040 0000000000000000 00 00001040ffffefbf 4
0 00002040 0000000000000000 00 00002040ffffdfbf 5
0 00001048 0000000000000000 00 00001048ffffefb7 5
0 00001840 0000000000000000 00 00001840ffffe7bf 6
1 00001068 deadbeefcafef00d ff 0000000000000000 7
0 00001860 0000000000000000 00 00001860ffffe79f 8
0 00002060 0000000000000000 00 00002060ffffdf9f 9
0 00001068 0000000000000000 00 deadbeefcafef00d 10
1 00000300 0123456789abcdef ff 0000000000000000 11
1 00001068 0f0e0d0c0b0a0908 3c 0000000000000000 11
2 00000000 0000000000000000 00 0000000000000000 11
0 00000300 0000000000000000 00 0123456789abcdef 12
0 00001068 0000000000000000 00 dead0d0c0b0af00d 13
0 00000110 0000000000000000 00 0000011055667788 14
0 00000208 0000000000000000 00 aabbccddfffffdf7 15
0 00002060 0000000000000000 00 00002060ffffdf9f 16

//--- sim/dcache_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_model (
    input  logic                          clk,
    input  logic                          rd_req_i,
    input  logic [dcache_pkg::ADDR_W-1:0] rd_addr_i,
    input  logic                          wr_req_i,
    input  dcache_pkg::mem_wr_t           wr_i,
    output logic                          rd_ack_o,
    output logic [dcache_pkg::LINE_W-1:0] rd_line_o,
    output logic                          wr_ack_o,
    output int unsigned                   rd_count_o
);
    import dcache_pkg::*;

    localparam int          DRIVE_DELAY = 10;
    localparam int          MAX_DELAY   = 5;
    localparam logic [31:0] SEED        = 32'h0a38_acff;

    logic [LINE_W-1:0] lines [logic [ADDR_W-1:0]];   // written back lines only
    logic              busy;
    int unsigned       delay;

    // untouched memory, word at A holds {A, ~A}
    function automatic logic [LINE_W-1:0] pattern_line(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] data;
        logic [ADDR_W-1:0] a;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            a = base + ADDR_W'(w * 8);
            data[w*WORD_W +: WORD_W] = {a, ~a};
        end
        return data;
    endfunction

    initial begin
        void'($urandom(SEED));
        rd_ack_o   = 1'b0;
        wr_ack_o   = 1'b0;
        rd_line_o  = '0;
        rd_count_o = 0;
        busy       = 1'b0;
        delay      = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            rd_ack_o = 1'b0;
            wr_ack_o = 1'b0;
            if (!busy && (rd_req_i || wr_req_i)) begin
                busy  = 1'b1;
                delay = $urandom % (MAX_DELAY + 1);   // back-pressure
                if (rd_req_i) begin
                    rd_count_o++;
                end
            end
            if (busy && delay == 0) begin
                busy = 1'b0;
                if (rd_req_i) begin
                    if (lines.exists(rd_addr_i)) begin
                        rd_line_o = lines[rd_addr_i];
                    end else begin
                        rd_line_o = pattern_line(rd_addr_i);
                    end
                    rd_ack_o = 1'b1;
                end else begin
                    lines[wr_i.addr] = wr_i.line;
                    wr_ack_o = 1'b1;
                end
            end else if (busy) begin
                delay--;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int    CLK_PERIOD      = 100;
    localparam int    DRIVE_DELAY     = 10;
    localparam int    RST_CYCLES      = 16;
    localparam int    FIELDS          = 6;     // op addr wdata wsel rdata count
    localparam int    MAX_CASES       = 64;
    localparam int    CYCLES_PER_CASE = 300;
    localparam string CASE_FILE       = "sim/dcache_cases.txt";

    logic                clk;
    logic                rst;
    logic                req_valid;
    core_req_t           req;
    logic                flush;
    logic                done;
    logic [WORD_W-1:0]   rdata;
    logic                flush_done;
    logic                mem_rd_req;
    logic [ADDR_W-1:0]   mem_rd_addr;
    logic                mem_rd_ack;
    logic [LINE_W-1:0]   mem_rd_line;
    logic                mem_wr_req;
    mem_wr_t             mem_wr;
    logic                mem_wr_ack;
    int unsigned         rd_count;

    logic [63:0]         case_mem [FIELDS*MAX_CASES];
    int                  num_cases;
    int                  cur_case;
    int                  errors;
    int                  checks;
    int                  cycle_cnt;
    int                  cycle_limit;

    dcache_top dcache_top_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid_i   (req_valid),
        .req_i         (req),
        .flush_i       (flush),
        .mem_rd_ack_i  (mem_rd_ack),
        .mem_rd_line_i (mem_rd_line),
        .mem_wr_ack_i  (mem_wr_ack),
        .done_o        (done),
        .rdata_o       (rdata),
        .flush_done_o  (flush_done),
        .mem_rd_req_o  (mem_rd_req),
        .mem_rd_addr_o (mem_rd_addr),
        .mem_wr_req_o  (mem_wr_req),
        .mem_wr_o      (mem_wr)
    );

    dcache_mem_model mem_model_i (
        .clk        (clk),
        .rd_req_i   (mem_rd_req),
        .rd_addr_i  (mem_rd_addr),
        .wr_req_i   (mem_wr_req),
        .wr_i       (mem_wr),
        .rd_ack_o   (mem_rd_ack),
        .rd_line_o  (mem_rd_line),
        .wr_ack_o   (mem_wr_ack),
        .rd_count_o (rd_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // one case per text line, comment lines fail the scan and are skipped
    task automatic read_cases();
        int          fd;
        int          n;
        string       text;
        logic [63:0] f [FIELDS];
        num_cases = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                text = "";
                void'($fgets(text, fd));
                n = $sscanf(text, "%d %h %h %h %h %d", f[0], f[1], f[2], f[3], f[4], f[5]);
                if (n == FIELDS) begin
                    for (int k = 0; k < FIELDS; k++) begin
                        case_mem[num_cases*FIELDS + k] = f[k];
                    end
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    // holds the request until done, returns the read word
    task automatic access(input cache_op_e op, input logic [63:0] addr, input logic [63:0] wdata,
                          input logic [63:0] wsel, output logic [63:0] word);
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = addr[ADDR_W-1:0];
        req.wdata = wdata;
        req.wsel  = wsel[WSEL_W-1:0];
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!done);
        word = rdata;
        @(posedge clk);
        #DRIVE_DELAY;
        req_valid = 1'b0;
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
        while (!flush_done) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(posedge clk);     // back in idle
        #DRIVE_DELAY;
    endtask

    task automatic run_case(input int c);
        logic [63:0] op;
        logic [63:0] word;
        op = case_mem[c*FIELDS];
        case (op)
            64'd0, 64'd1: begin
                access(cache_op_e'(op[0]), case_mem[c*FIELDS+1], case_mem[c*FIELDS+2],
                       case_mem[c*FIELDS+3], word);
                if (op == 64'd0) begin
                    check("rdata_o", word, case_mem[c*FIELDS+4]);
                end
            end
            64'd2: flush_cache();
            default: begin
                errors++;
                $display("error: case %0d has an unknown op %0h", c, op);
            end
        endcase
        check("mem_rd_count", 64'(rd_count), case_mem[c*FIELDS+5]);
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("error: timeout after %0d cycles in case %0d", cycle_cnt, cur_case);
        $display("errors: %0d, checks: %0d, timeouts: 1", errors, checks);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        int i;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        flush       = 1'b0;
        errors      = 0;
        checks      = 0;
        cur_case    = 0;
        cycle_limit = 0;
        read_cases();
        if (num_cases == 0) begin
            errors++;
            $display("error: no cases read from %s", CASE_FILE);
        end
        cycle_limit = RST_CYCLES + 1 + num_cases * CYCLES_PER_CASE;

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        for (i = 0; i < num_cases; i++) begin
            cur_case = i;
            run_case(i);
        end

        $display("errors: %0d, checks: %0d, cases: %0d", errors, checks, num_cases);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
